// ==== common/ppu_out_cfg.svh ====
// Video output configuration constants: field positions, limiting and latency
`ifndef PPU_OUT_CFG_SVH
`define PPU_OUT_CFG_SVH

// ==============================
// Widths
// ==============================

// Bits per colour channel
`define COLOR_W 8

// Configuration word coming from the system side
`define PPU_CFG_W 9

// ==============================
// Configuration word layout
// ==============================

// Target resolution field, bits 3..0
`define CFG_TARGET_LSB 0
`define CFG_TARGET_W 4

`define CFG_USE_VGA_BIT 4
`define CFG_FORCE50_BIT 5
`define CFG_FORCE60_BIT 6
`define CFG_LLM_BIT 7
`define CFG_LIMITED_RGB_BIT 8

// ==============================
// Limited range RGB
// ==============================

// Scale by 220/256, then lift into 16..235
`define LIMIT_COEFF 220
`define LIMIT_OFFSET 16

// Pixel input to output depth in clocks
`define OUT_LATENCY 3

`endif

// ==== common/ppu_out_pkg.sv ====
// Shared pixel, sync and video mode types for the video output path
`default_nettype none

`include "ppu_out_cfg.svh"

package ppu_out_pkg;

  // One output pixel
  typedef struct packed {
    logic [`COLOR_W-1:0] r;
    logic [`COLOR_W-1:0] g;
    logic [`COLOR_W-1:0] b;
  } rgb_t;

  // Sync levels travelling alongside the pixel
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } sync_t;

  // Output video modes, 60Hz family first
  typedef enum logic [3:0] {
    VM_240P60,
    VM_480P60,
    VM_VGAP60,
    VM_720P60,
    VM_960P60,
    VM_1080P60,
    VM_1200P60,
    VM_1440P60,
    VM_288P50,
    VM_576P50,
    VM_720P50,
    VM_960P50,
    VM_1080P50,
    VM_1200P50,
    VM_1440P50
  } videomode_e;

  // Requested target resolution as coded in the config word
  typedef enum logic [`CFG_TARGET_W-1:0] {
    TGT_240P,
    TGT_288P,
    TGT_480P,
    TGT_576P,
    TGT_720P,
    TGT_960P,
    TGT_1080P,
    TGT_1200P,
    TGT_1440P
  } target_res_e;

endpackage

`default_nettype wire

// ==== src/pipe_delay.sv ====
// Fixed-depth delay line for an arbitrary packed payload
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  wire    VCLK_Tx,
  input  wire    nVRST_Tx,
  input  wire T  data_i,
  output T       data_o
);

  // Stage 0 takes the input, last stage feeds the output
  T stage_q [DEPTH];

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== rgb_limit/limit_channel.sv ====
// Scale one colour channel by 220/256 with half-up rounding, two stages
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module limit_channel (
  input  wire                 VCLK_Tx,
  input  wire                 nVRST_Tx,
  input  wire [`COLOR_W-1:0]  chan_i,
  output logic [`COLOR_W-1:0] chan_o
);

  localparam int unsigned PROD_W = 2 * `COLOR_W;
  localparam logic [PROD_W-1:0] COEFF = PROD_W'(`LIMIT_COEFF);

  logic [PROD_W-1:0]   product;
  logic [`COLOR_W:0]   scaled_q;
  logic [`COLOR_W-1:0] round_q;

  assign product = PROD_W'(chan_i) * COEFF;

  // Stage 1 keeps product / 128, stage 2 halves it and adds the dropped
  // bit back, i.e. rounds product / 256 half up
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      scaled_q <= '0;
      round_q  <= '0;
    end else begin
      scaled_q <= product[PROD_W-1 -: `COLOR_W+1];
      round_q  <= scaled_q[`COLOR_W:1] + `COLOR_W'(scaled_q[0]);
    end
  end

  assign chan_o = round_q;

endmodule

`default_nettype wire

// ==== rgb_limit/rgb_limiter.sv ====
// Full or limited range RGB selection over a three-stage colour pipeline
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module rgb_limiter (
  input  wire                 VCLK_Tx,
  input  wire                 nVRST_Tx,
  input  wire                 limited_rgb_en_i,
  input  wire ppu_out_pkg::rgb_t vd_i,
  output ppu_out_pkg::rgb_t   vd_o
);

  import ppu_out_pkg::*;

  // Offset lands on the upper nibble only
  localparam logic [`COLOR_W-5:0] OFFS_HI = (`COLOR_W-4)'(`LIMIT_OFFSET >> 4);

  logic [`COLOR_W-1:0] lim_r;
  logic [`COLOR_W-1:0] lim_g;
  logic [`COLOR_W-1:0] lim_b;
  rgb_t                full_dly;

  function automatic logic [`COLOR_W-1:0] add_offset(input logic [`COLOR_W-1:0] c);
    return {c[`COLOR_W-1:4] + OFFS_HI, c[3:0]};
  endfunction

  // ==============================
  // Stages 1 and 2
  // ==============================

  limit_channel u_limit_r (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .chan_i   (vd_i.r),
    .chan_o   (lim_r)
  );

  limit_channel u_limit_g (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .chan_i   (vd_i.g),
    .chan_o   (lim_g)
  );

  limit_channel u_limit_b (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .chan_i   (vd_i.b),
    .chan_o   (lim_b)
  );

  // Full-range pixel kept in step with the scaled channels
  pipe_delay #(
    .T     (rgb_t),
    .DEPTH (2)
  ) u_full_dly (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .data_i   (vd_i),
    .data_o   (full_dly)
  );

  // ==============================
  // Stage 3, output register
  // ==============================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vd_o <= '0;
    end else if (limited_rgb_en_i) begin
      vd_o.r <= add_offset(lim_r);
      vd_o.g <= add_offset(lim_g);
      vd_o.b <= add_offset(lim_b);
    end else begin
      vd_o <= full_dly;
    end
  end

endmodule

`default_nettype wire

// ==== cfg_decode/out_cfg_decode.sv ====
// Config resync into VCLK_Tx and output video mode / limited RGB decode
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module out_cfg_decode (
  input  wire                     VCLK_Tx,
  input  wire                     nVRST_Tx,
  input  wire [`PPU_CFG_W-1:0]    config_i,
  input  wire                     palmode_i,
  output ppu_out_pkg::videomode_e videomode_o,
  output logic                    limited_rgb_en_o
);

  import ppu_out_pkg::*;

  logic [`PPU_CFG_W-1:0] cfg_meta_q;
  logic [`PPU_CFG_W-1:0] cfg_sync_q;
  logic                  pal_meta_q;
  logic                  pal_sync_q;

  target_res_e target;
  logic        use_vga;
  logic        force50;
  logic        force60;
  logic        llm;
  videomode_e  vmode_ntsc;
  videomode_e  vmode_pal;
  videomode_e  vmode_sel;

  // ==============================
  // Two-stage synchronizer
  // ==============================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_meta_q <= '0;
      cfg_sync_q <= '0;
      pal_meta_q <= 1'b0;
      pal_sync_q <= 1'b0;
    end else begin
      cfg_meta_q <= config_i;
      cfg_sync_q <= cfg_meta_q;
      pal_meta_q <= palmode_i;
      pal_sync_q <= pal_meta_q;
    end
  end

  // Field split of the resynced word
  assign target  = target_res_e'(cfg_sync_q[`CFG_TARGET_LSB +: `CFG_TARGET_W]);
  assign use_vga = cfg_sync_q[`CFG_USE_VGA_BIT];
  assign force50 = cfg_sync_q[`CFG_FORCE50_BIT];
  assign force60 = cfg_sync_q[`CFG_FORCE60_BIT];
  assign llm     = cfg_sync_q[`CFG_LLM_BIT];

  // ==============================
  // Mode candidates
  // ==============================

  always_comb begin
    case (target)
      TGT_1440P: vmode_ntsc = VM_1440P60;
      TGT_1200P: vmode_ntsc = VM_1200P60;
      TGT_1080P: vmode_ntsc = VM_1080P60;
      TGT_960P:  vmode_ntsc = VM_960P60;
      TGT_720P:  vmode_ntsc = VM_720P60;
      TGT_240P:  vmode_ntsc = VM_240P60;
      default:   vmode_ntsc = use_vga ? VM_VGAP60 : VM_480P60;
    endcase

    case (target)
      TGT_1440P: vmode_pal = VM_1440P50;
      TGT_1200P: vmode_pal = VM_1200P50;
      TGT_1080P: vmode_pal = VM_1080P50;
      TGT_960P:  vmode_pal = VM_960P50;
      TGT_720P:  vmode_pal = VM_720P50;
      TGT_576P:  vmode_pal = VM_576P50;
      default:   vmode_pal = VM_288P50;
    endcase
  end

  // Forcing is blocked in low latency mode and for the native-rate targets
  always_comb begin
    if (force60 && !llm && (target != TGT_288P)) begin
      vmode_sel = vmode_ntsc;
    end else if (force50 && !llm && (target != TGT_240P)) begin
      vmode_sel = vmode_pal;
    end else begin
      vmode_sel = pal_sync_q ? vmode_pal : vmode_ntsc;
    end
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      videomode_o      <= VM_240P60;
      limited_rgb_en_o <= 1'b0;
    end else begin
      videomode_o      <= vmode_sel;
      limited_rgb_en_o <= cfg_sync_q[`CFG_LIMITED_RGB_BIT];
    end
  end

endmodule

`default_nettype wire

// ==== src/ppu_out_top.sv ====
// Video output top level: config decode, sync delay and RGB range limiting
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module ppu_out_top (
  input  wire                     VCLK_Tx,
  input  wire                     nVRST_Tx,
  input  wire [`PPU_CFG_W-1:0]    config_i,
  input  wire                     palmode_i,
  input  wire                     vsync_i,
  input  wire                     hsync_i,
  input  wire                     de_i,
  input  wire ppu_out_pkg::rgb_t  vd_i,
  output logic                    vsync_o,
  output logic                    hsync_o,
  output logic                    de_o,
  output ppu_out_pkg::rgb_t       vd_o,
  output ppu_out_pkg::videomode_e videomode_o
);

  import ppu_out_pkg::*;

  logic  limited_rgb_en;
  sync_t sync_in;
  sync_t sync_out;

  assign sync_in = {vsync_i, hsync_i, de_i};

  out_cfg_decode u_cfg_decode (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .config_i         (config_i),
    .palmode_i        (palmode_i),
    .videomode_o      (videomode_o),
    .limited_rgb_en_o (limited_rgb_en)
  );

  // Syncs follow the colour path latency
  pipe_delay #(
    .T     (sync_t),
    .DEPTH (`OUT_LATENCY)
  ) u_sync_dly (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .data_i   (sync_in),
    .data_o   (sync_out)
  );

  rgb_limiter u_rgb_limiter (
    .VCLK_Tx          (VCLK_Tx),
    .nVRST_Tx         (nVRST_Tx),
    .limited_rgb_en_i (limited_rgb_en),
    .vd_i             (vd_i),
    .vd_o             (vd_o)
  );

  assign vsync_o = sync_out.vsync;
  assign hsync_o = sync_out.hsync;
  assign de_o    = sync_out.de;

endmodule

`default_nettype wire

// ==== tb/ppu_out_chk.sv ====
// Bound assertion checker for the video output top level
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module ppu_out_chk (
  input wire                         VCLK_Tx,
  input wire                         nVRST_Tx,
  input wire                         de_i,
  input wire                         limited_rgb_en_i,
  input wire                         vsync_o,
  input wire                         hsync_o,
  input wire                         de_o,
  input wire ppu_out_pkg::rgb_t      vd_o,
  input wire ppu_out_pkg::videomode_e videomode_o
);

  import ppu_out_pkg::*;

  int unsigned fail_count = 0;

  function automatic logic in_range(input logic [`COLOR_W-1:0] c);
    return (c >= 8'd16) && (c <= 8'd235);
  endfunction

  // Everything reads zero while reset is held across an edge
  a_reset_clear: assert property (@(posedge VCLK_Tx)
    (!nVRST_Tx && !$past(nVRST_Tx)) |->
      (!vsync_o && !hsync_o && !de_o && (vd_o == '0) && (videomode_o == VM_240P60)))
  else begin
    $error("outputs not cleared while reset is held");
    fail_count++;
  end

  // DE only compared once the whole sync pipe has left reset
  a_de_delay: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    ($past(nVRST_Tx, 1) && $past(nVRST_Tx, 2) && $past(nVRST_Tx, `OUT_LATENCY))
      |-> (de_o == $past(de_i, `OUT_LATENCY)))
  else begin
    $error("de_o does not follow de_i by the output latency");
    fail_count++;
  end

  // Output register took the enable one edge back
  a_limit_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $past(limited_rgb_en_i) |-> (in_range(vd_o.r) && in_range(vd_o.g) && in_range(vd_o.b)))
  else begin
    $error("limited RGB channel outside 16..235");
    fail_count++;
  end

endmodule

bind ppu_out_top ppu_out_chk u_chk (
  .VCLK_Tx          (VCLK_Tx),
  .nVRST_Tx         (nVRST_Tx),
  .de_i             (de_i),
  .limited_rgb_en_i (limited_rgb_en),
  .vsync_o          (vsync_o),
  .hsync_o          (hsync_o),
  .de_o             (de_o),
  .vd_o             (vd_o),
  .videomode_o      (videomode_o)
);

`default_nettype wire

// ==== tb/tb_ppu_out.sv ====
// Testbench for the video output top level with random pixels and config
`timescale 1ns/1ps
`default_nettype none

`include "ppu_out_cfg.svh"

module tb_ppu_out;

  import ppu_out_pkg::*;

  typedef struct packed {
    sync_t sync;
    rgb_t  pix;
  } in_rec_t;

  localparam int SEG_LEN  = 64;
  localparam int SKIP_LEN = 8;
  localparam int NUM_SEGS = 48;

  logic                  VCLK_Tx;
  logic                  nVRST_Tx;
  logic [`PPU_CFG_W-1:0] config_i;
  logic                  palmode_i;
  logic                  vsync_i;
  logic                  hsync_i;
  logic                  de_i;
  rgb_t                  vd_i;
  logic                  vsync_o;
  logic                  hsync_o;
  logic                  de_o;
  rgb_t                  vd_o;
  videomode_e            videomode_o;

  logic [15:0]           lfsr_state = 16'd96;
  in_rec_t               pipe_q[$];
  logic [`PPU_CFG_W-1:0] cur_cfg;
  logic                  cur_pal;
  int                    value_errors = 0;
  int                    other_errors = 0;

  ppu_out_top ppu_out_top_inst (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .config_i    (config_i),
    .palmode_i   (palmode_i),
    .vsync_i     (vsync_i),
    .hsync_i     (hsync_i),
    .de_i        (de_i),
    .vd_i        (vd_i),
    .vsync_o     (vsync_o),
    .hsync_o     (hsync_o),
    .de_o        (de_o),
    .vd_o        (vd_o),
    .videomode_o (videomode_o)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #20 VCLK_Tx = ~VCLK_Tx;
  end

  // ==============================
  // Stimulus and reference model
  // ==============================

  // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // Extremes show up often to hit 16 and 235
  function automatic logic [`COLOR_W-1:0] random_chan();
    logic [31:0] sel;
    sel = take_bits(3);
    case (sel[2:0])
      3'd0:    return 8'h00;
      3'd1:    return 8'hFF;
      default: return 8'(take_bits(`COLOR_W));
    endcase
  endfunction

  function automatic in_rec_t random_record();
    in_rec_t     rec;
    logic [31:0] s;
    s = take_bits(3);
    rec.sync  = s[2:0];
    rec.pix.r = random_chan();
    rec.pix.g = random_chan();
    rec.pix.b = random_chan();
    return rec;
  endfunction

  function automatic logic [`COLOR_W-1:0] limit_chan(input logic [`COLOR_W-1:0] v);
    int unsigned scaled;
    scaled = (32'(v) * `LIMIT_COEFF + 128) / 256;
    return 8'(scaled + `LIMIT_OFFSET);
  endfunction

  // Targets from 720p up map onto the matching mode in enum order
  function automatic videomode_e expected_mode(input logic [`PPU_CFG_W-1:0] cfg,
                                               input logic pal);
    logic [3:0] tgt;
    logic       llm;
    logic       force_ntsc;
    logic       force_pal;
    videomode_e ntsc;
    videomode_e pal_m;
    tgt = cfg[`CFG_TARGET_LSB +: 4];
    llm = cfg[`CFG_LLM_BIT];
    if (tgt >= TGT_720P) begin
      ntsc  = videomode_e'(VM_720P60 + (tgt - TGT_720P));
      pal_m = videomode_e'(VM_720P50 + (tgt - TGT_720P));
    end else begin
      if (tgt == TGT_240P) begin
        ntsc = VM_240P60;
      end else begin
        ntsc = cfg[`CFG_USE_VGA_BIT] ? VM_VGAP60 : VM_480P60;
      end
      pal_m = (tgt == TGT_576P) ? VM_576P50 : VM_288P50;
    end
    force_ntsc = cfg[`CFG_FORCE60_BIT] && !llm && (tgt != TGT_288P);
    force_pal  = cfg[`CFG_FORCE50_BIT] && !llm && (tgt != TGT_240P);
    return force_ntsc ? ntsc : (force_pal ? pal_m : (pal ? pal_m : ntsc));
  endfunction

  // ==============================
  // Checks and drive tasks
  // ==============================

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL t=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_reset_outputs();
    check_value("vsync_o", 32'd0, 32'(vsync_o));
    check_value("hsync_o", 32'd0, 32'(hsync_o));
    check_value("de_o", 32'd0, 32'(de_o));
    check_value("vd_o", 32'd0, 32'(vd_o));
    check_value("videomode_o", 32'(VM_240P60), 32'(videomode_o));
  endtask

  task automatic drive_inputs(input in_rec_t rec);
    vsync_i = rec.sync.vsync;
    hsync_i = rec.sync.hsync;
    de_i    = rec.sync.de;
    vd_i    = rec.pix;
  endtask

  task automatic next_slot();
    @(posedge VCLK_Tx);
    #2;
  endtask

  // Compare the pixel from OUT_LATENCY slots back, then drive a new one
  task automatic pixel_slot(input bit do_check);
    in_rec_t rec;
    rgb_t    exp_pix;
    if (pipe_q.size() == `OUT_LATENCY) begin
      rec = pipe_q.pop_front();
      if (do_check) begin
        exp_pix = rec.pix;
        if (cur_cfg[`CFG_LIMITED_RGB_BIT]) begin
          exp_pix.r = limit_chan(rec.pix.r);
          exp_pix.g = limit_chan(rec.pix.g);
          exp_pix.b = limit_chan(rec.pix.b);
        end
        check_value("vsync_o", 32'(rec.sync.vsync), 32'(vsync_o));
        check_value("hsync_o", 32'(rec.sync.hsync), 32'(hsync_o));
        check_value("de_o", 32'(rec.sync.de), 32'(de_o));
        check_value("vd_o", 32'(exp_pix), 32'(vd_o));
        check_value("videomode_o", 32'(expected_mode(cur_cfg, cur_pal)), 32'(videomode_o));
      end
    end
    rec = random_record();
    drive_inputs(rec);
    pipe_q.push_back(rec);
  endtask

  // Release lands on a slot so the refill stays aligned with the queue
  task automatic hold_reset(input int cycles);
    for (int i = 0; i < cycles - 1; i++) begin
      next_slot();
      check_reset_outputs();
      drive_inputs(random_record());
    end
    next_slot();
    nVRST_Tx = 1'b1;
    pipe_q.delete();
    pixel_slot(1'b0);
  endtask

  task automatic reset_midstream();
    next_slot();
    #10;
    nVRST_Tx = 1'b0;
    #1;
    check_reset_outputs();
    hold_reset(4);
  endtask

  task automatic run_segment();
    logic [31:0] pal_bits;
    int          n;
    next_slot();
    cur_cfg = `PPU_CFG_W'(take_bits(`PPU_CFG_W));
    cur_cfg[3:0] = cur_cfg[3:0] % 4'd9;
    pal_bits = take_bits(1);
    cur_pal = pal_bits[0];
    config_i = cur_cfg;
    palmode_i = cur_pal;
    pixel_slot(1'b0);
    n = 1;
    // Two sync stages plus the decode register
    while ((videomode_o !== expected_mode(cur_cfg, cur_pal)) && (n < SKIP_LEN)) begin
      next_slot();
      pixel_slot(1'b0);
      n++;
    end
    if (videomode_o !== expected_mode(cur_cfg, cur_pal)) begin
      other_errors++;
      $display("Timeout: videomode_o did not settle within %0d cycles of a config change",
               SKIP_LEN);
    end
    while (n < SKIP_LEN) begin
      next_slot();
      pixel_slot(1'b0);
      n++;
    end
    while (n < SEG_LEN) begin
      next_slot();
      pixel_slot(1'b1);
      n++;
    end
  endtask

  initial begin
    int total;
    nVRST_Tx  = 1'b0;
    config_i  = '0;
    palmode_i = 1'b0;
    vsync_i   = 1'b0;
    hsync_i   = 1'b0;
    de_i      = 1'b0;
    vd_i      = '0;
    cur_cfg   = '0;
    cur_pal   = 1'b0;
    hold_reset(10);
    for (int s = 0; s < NUM_SEGS; s++) begin
      run_segment();
      if (s == NUM_SEGS / 2) begin
        reset_midstream();
      end
    end
    total = value_errors + other_errors + ppu_out_top_inst.u_chk.fail_count;
    $display("Summary: %0d value mismatches, %0d timeouts, %0d assertion failures",
             value_errors, other_errors, ppu_out_top_inst.u_chk.fail_count);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ppu_out.f ====
+incdir+common
common/ppu_out_pkg.sv
src/pipe_delay.sv
rgb_limit/limit_channel.sv
rgb_limit/rgb_limiter.sv
cfg_decode/out_cfg_decode.sv
src/ppu_out_top.sv
tb/ppu_out_chk.sv
tb/tb_ppu_out.sv

// ==== Makefile ====
# Verilator build, run and lint for the video output testbench

TOP := tb_ppu_out

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ppu_out.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only --timing --assert -f ppu_out.f --top-module $(TOP)

clean:
	rm -rf obj_dir
